// ==== design/oled_pkg.sv ====
package oled_pkg;

    // power-up sequence and frame geometry of the SSD1306 panel
    localparam int init_cmds   = 32;
    // 128 columns by 4 pages
    localparam int frame_bytes = 512;

    // index within the phase being sent
    typedef logic [8:0] byte_idx_t;

    // one command or pixel byte
    typedef logic [7:0] oled_data_t;

    typedef enum logic {
        PH_INIT,
        PH_FRAME
    } phase_t;

    // byte as handed to the I2C layer
    typedef struct packed {
        // data control byte when set, command control byte otherwise
        logic       is_data;
        // Co bit, more control bytes follow in the same transfer
        logic       cont;
        oled_data_t value;
    } oled_byte_t;

endpackage

// ==== design/pet_pkg.sv ====
package pet_pkg;

    // life and food run 0 to 100
    typedef logic [6:0] level_t;

    typedef struct packed {
        logic   disease;
        level_t life;
        level_t food;
    } pet_status_t;

    // each threshold passed adds half a heart
    localparam level_t life_steps [5] = '{7'd16, 7'd33, 7'd50, 7'd67, 7'd83};
    // each threshold passed adds one food icon
    localparam level_t food_steps [2] = '{7'd33, 7'd67};

    // positions are byte offsets into the frame
    localparam int heart_base  = 483;
    localparam int heart_pitch = 9;
    localparam int food_base   = 31;
    localparam int food_pitch  = 10;
    localparam int sick_base   = 106;
    localparam int sick_len    = 11;

    // hearts and food icons share the same width
    localparam int glyph_len = 7;
    // left part of a heart kept for a half heart
    localparam int half_len  = 4;

    localparam logic [7:0] heart_glyph [7] = '{8'h0E, 8'h1D, 8'h3F, 8'h7E, 8'h3F, 8'h1F, 8'h0E};
    localparam logic [7:0] food_glyph  [7] = '{8'h70, 8'h88, 8'h88, 8'h86, 8'h8B, 8'h89, 8'h70};
    localparam logic [7:0] sick_glyph [11] = '{8'h78, 8'hFC, 8'hFC, 8'hFE, 8'hED, 8'hC5,
                                              8'hED, 8'hFE, 8'hFC, 8'hFC, 8'hF8};

endpackage

// ==== design/refresh_fsm.sv ====
`timescale 1ns/1ps

module refresh_fsm
    import oled_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   status_valid,
    output logic   status_ready,
    input  logic   out_ready,
    output logic   out_valid,
    input  logic   last,
    output phase_t phase,
    output logic   advance,
    output logic   clear
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_INIT,
        SEND_FRAME
    } state_t;

    state_t state;
    // init sequence already sent since reset
    logic   panel_ready;

    assign status_ready = (state == IDLE);
    assign out_valid    = (state != IDLE);
    assign phase        = (state == SEND_INIT) ? PH_INIT : PH_FRAME;
    assign advance      = out_valid && out_ready;
    assign clear        = advance && last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            panel_ready <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (status_valid) begin
                        state <= panel_ready ? SEND_FRAME : SEND_INIT;
                    end
                end
                SEND_INIT: begin
                    if (clear) begin
                        state       <= SEND_FRAME;
                        panel_ready <= 1'b1;
                    end
                end
                SEND_FRAME: begin
                    if (clear) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a stalled byte is never withdrawn
    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid);

endmodule

// ==== design/byte_counter.sv ====
`timescale 1ns/1ps

module byte_counter
    import oled_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  phase_t    phase,
    input  logic      advance,
    input  logic      clear,
    output byte_idx_t index,
    output logic      last
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (advance) begin
            index <= index + 1'b1;
        end
    end

    // terminal count depends on the phase
    always_comb begin
        if (phase == PH_INIT) begin
            last = (index == byte_idx_t'(init_cmds - 1));
        end else begin
            last = (index == byte_idx_t'(frame_bytes - 1));
        end
    end

    // clear from the FSM must arrive before the command table runs out
    a_init_range: assert property (@(posedge clk) disable iff (!rst_n)
        phase == PH_INIT |-> index <= byte_idx_t'(init_cmds - 1));

endmodule

// ==== design/init_cmd_rom.sv ====
`timescale 1ns/1ps

module init_cmd_rom
    import oled_pkg::*;
(
    input  byte_idx_t  index,
    output oled_byte_t cmd
);

    oled_data_t value;

    always_comb begin
        case (index)
            9'd0:    value = 8'hAE;  // display off
            9'd1:    value = 8'hD5;
            9'd2:    value = 8'h80;
            9'd3:    value = 8'hA8;  // multiplex 32 rows
            9'd4:    value = 8'h1F;
            9'd5:    value = 8'hD3;
            9'd6:    value = 8'h00;
            9'd7:    value = 8'h40;
            9'd8:    value = 8'h8D;  // charge pump on
            9'd9:    value = 8'h14;
            9'd10:   value = 8'h20;  // horizontal addressing
            9'd11:   value = 8'h00;
            9'd12:   value = 8'hA1;
            9'd13:   value = 8'hC8;
            9'd14:   value = 8'hDA;
            9'd15:   value = 8'h02;
            9'd16:   value = 8'h81;  // contrast
            9'd17:   value = 8'h8F;
            9'd18:   value = 8'hD9;
            9'd19:   value = 8'hF1;
            9'd20:   value = 8'hDB;
            9'd21:   value = 8'h40;
            9'd22:   value = 8'hA4;
            9'd23:   value = 8'hA6;
            9'd24:   value = 8'h2E;
            9'd25:   value = 8'hAF;  // display on
            // page window then column window
            9'd26:   value = 8'h22;
            9'd27:   value = 8'h00;
            9'd28:   value = 8'hFF;
            9'd29:   value = 8'h21;
            9'd30:   value = 8'h00;
            9'd31:   value = 8'h7F;
            default: value = 8'h00;
        endcase
    end

    // grouping of commands into I2C runs
    assign cmd.is_data = 1'b0;
    assign cmd.cont    = index inside {[0:2], [5:7], [10:12], [20:24], [26:29]};
    assign cmd.value   = value;

endmodule

// ==== design/status_overlay.sv ====
`timescale 1ns/1ps

module status_overlay
    import oled_pkg::*;
    import pet_pkg::*;
(
    input  byte_idx_t   index,
    input  pet_status_t status,
    output oled_byte_t  pixel
);

    // half hearts to draw, 0 to 6
    logic [2:0] halves;
    // food icons to draw, 0 to 3
    logic [1:0] food_cnt;
    oled_data_t value;

    // thresholds are ascending, so counting the ones passed gives the level
    always_comb begin
        halves = (status.life != '0) ? 3'd1 : 3'd0;
        for (int i = 0; i < 5; i++) begin
            if (status.life > life_steps[i]) begin
                halves = halves + 3'd1;
            end
        end
    end

    always_comb begin
        food_cnt = (status.food != '0) ? 2'd1 : 2'd0;
        for (int i = 0; i < 2; i++) begin
            if (status.food > food_steps[i]) begin
                food_cnt = food_cnt + 2'd1;
            end
        end
    end

    always_comb begin
        int off;

        value = '0;
        for (int k = 0; k < 3; k++) begin
            // heart k
            off = int'(index) - (heart_base + k * heart_pitch);
            if (off >= 0 && off < glyph_len) begin
                if (int'(halves) >= 2 * k + 2) begin
                    value = heart_glyph[off[2:0]];
                end else if (int'(halves) == 2 * k + 1 && off < half_len) begin
                    value = heart_glyph[off[2:0]];
                end
            end

            // food icon k
            off = int'(index) - (food_base + k * food_pitch);
            if (off >= 0 && off < glyph_len && k < int'(food_cnt)) begin
                value = food_glyph[off[2:0]];
            end
        end

        off = int'(index) - sick_base;
        if (status.disease && off >= 0 && off < sick_len) begin
            value = sick_glyph[off[3:0]];
        end
    end

    assign pixel.is_data = 1'b1;
    assign pixel.cont    = 1'b0;
    assign pixel.value   = value;

endmodule

// ==== design/pet_display_top.sv ====
`timescale 1ns/1ps

module pet_display_top
    import oled_pkg::*;
    import pet_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  pet_status_t status,
    input  logic        status_valid,
    output logic        status_ready,
    output oled_byte_t  out_byte,
    output logic        out_valid,
    input  logic        out_ready
);

    pet_status_t status_q;
    phase_t      phase;
    logic        advance;
    logic        clear;
    logic        last;
    byte_idx_t   index;
    oled_byte_t  cmd_byte;
    oled_byte_t  frame_byte;

    // frame is drawn from the status seen at accept
    always_ff @(posedge clk) begin
        if (status_valid && status_ready) begin
            status_q <= status;
        end
    end

    refresh_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .status_valid(status_valid),
        .status_ready(status_ready),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .last        (last),
        .phase       (phase),
        .advance     (advance),
        .clear       (clear)
    );

    byte_counter u_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .phase  (phase),
        .advance(advance),
        .clear  (clear),
        .index  (index),
        .last   (last)
    );

    init_cmd_rom u_rom (
        .index(index),
        .cmd  (cmd_byte)
    );

    status_overlay u_overlay (
        .index (index),
        .status(status_q),
        .pixel (frame_byte)
    );

    assign out_byte = (phase == PH_INIT) ? cmd_byte : frame_byte;

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

// ==== bench/pet_display_tb.sv ====
`timescale 1ns/1ps

module pet_display_tb
    import oled_pkg::*;
    import pet_pkg::*;
();

    typedef struct packed {
        pet_status_t status;
        // put on the status input while the refresh runs
        pet_status_t late;
    } stim_row_t;

    localparam int num_rows       = 6;
    localparam int timeout_cycles = 4 * (init_cmds + num_rows * frame_bytes) + 200;

    localparam logic [7:0] init_values [32] = '{
        8'hAE, 8'hD5, 8'h80, 8'hA8, 8'h1F, 8'hD3, 8'h00, 8'h40,
        8'h8D, 8'h14, 8'h20, 8'h00, 8'hA1, 8'hC8, 8'hDA, 8'h02,
        8'h81, 8'h8F, 8'hD9, 8'hF1, 8'hDB, 8'h40, 8'hA4, 8'hA6,
        8'h2E, 8'hAF, 8'h22, 8'h00, 8'hFF, 8'h21, 8'h00, 8'h7F};
    // bit i set where command byte i has Co set
    localparam logic [31:0] cont_mask = 32'h3DF0_1CE7;

    logic        clk;
    logic        rst_n;
    pet_status_t status;
    logic        status_valid;
    logic        status_ready;
    oled_byte_t  out_byte;
    logic        out_valid;
    logic        out_ready;

    stim_row_t   rows [num_rows];
    logic [31:0] lfsr_state  = 32'he000_9c52;
    int          cycle_count = 0;

    tb_clock #(.period_ns(8)) u_clock (.clk(clk));

    pet_display_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .status      (status),
        .status_valid(status_valid),
        .status_ready(status_ready),
        .out_byte    (out_byte),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    // Fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        logic b;
        b = lfsr_state[31];
        lfsr_state = lfsr_step(lfsr_state);
        return b;
    endfunction

    function automatic int random_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(random_bit());
        end
        return v;
    endfunction

    function automatic pet_status_t make_status(logic d, int life, int food);
        return '{disease: d, life: level_t'(life), food: level_t'(food)};
    endfunction

    function automatic oled_byte_t frame_ref(int pos, pet_status_t s);
        int life;
        int food;
        int halves;
        int icons;
        int off;
        oled_byte_t b;

        life   = int'(s.life);
        food   = int'(s.food);
        halves = (life > 83) ? 6 : (life > 67) ? 5 : (life > 50) ? 4 :
                 (life > 33) ? 3 : (life > 16) ? 2 : (life > 0) ? 1 : 0;
        icons  = (food > 67) ? 3 : (food > 33) ? 2 : (food > 0) ? 1 : 0;
        b = '{is_data: 1'b1, cont: 1'b0, value: 8'h00};
        for (int k = 0; k < 3; k++) begin
            off = pos - (heart_base + heart_pitch * k);
            // a half heart keeps only its left four columns
            if (off >= 0 && off < 7 &&
                (halves >= 2 * k + 2 || (halves == 2 * k + 1 && off < 4))) begin
                b.value = heart_glyph[off[2:0]];
            end
            off = pos - (food_base + food_pitch * k);
            if (off >= 0 && off < 7 && k < icons) begin
                b.value = food_glyph[off[2:0]];
            end
        end
        off = pos - sick_base;
        if (s.disease && off >= 0 && off < 11) begin
            b.value = sick_glyph[off[3:0]];
        end
        return b;
    endfunction

    function automatic oled_byte_t expected_byte(int pos, logic with_init, pet_status_t s);
        oled_byte_t b;
        if (with_init && pos < init_cmds) begin
            b = '{is_data: 1'b0, cont: cont_mask[pos[4:0]], value: init_values[pos[4:0]]};
        end else begin
            b = frame_ref(with_init ? pos - init_cmds : pos, s);
        end
        return b;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic run_refresh(stim_row_t row, logic with_init, int r);
        int gap;
        int total;
        int sent;
        logic stalled;
        oled_byte_t held;
        oled_byte_t exp_b;

        gap = random_bits(2);
        repeat (gap) begin
            @(posedge clk);
            out_ready <= random_bit();
            @(negedge clk);
            assert (out_valid === 1'b0)
                else report_mismatch($sformatf("row %0d idle valid", r), 0, 32'(out_valid));
        end
        @(posedge clk);
        status       <= row.status;
        status_valid <= 1'b1;
        out_ready    <= random_bit();
        @(negedge clk);
        assert (status_ready === 1'b1)
            else report_mismatch($sformatf("row %0d idle ready", r), 1, 32'(status_ready));
        @(posedge clk);
        status_valid <= 1'b0;
        status       <= row.late;
        out_ready    <= random_bit();

        total   = with_init ? init_cmds + frame_bytes : frame_bytes;
        sent    = 0;
        stalled = 1'b0;
        held    = '0;
        while (sent < total) begin
            @(negedge clk);
            assert (out_valid === 1'b1)
                else report_mismatch($sformatf("row %0d valid @%0d", r, sent), 1, 32'(out_valid));
            assert (status_ready === 1'b0)
                else report_mismatch($sformatf("row %0d busy @%0d", r, sent), 0, 32'(status_ready));
            if (stalled) begin
                assert (out_byte === held)
                    else report_mismatch($sformatf("row %0d hold @%0d", r, sent),
                                         32'(held), 32'(out_byte));
            end
            exp_b = expected_byte(sent, with_init, row.status);
            assert (out_byte === exp_b)
                else report_mismatch($sformatf("row %0d byte %0d", r, sent),
                                     32'(exp_b), 32'(out_byte));
            stalled = !out_ready;
            held    = out_byte;
            if (out_ready) begin
                sent++;
            end
            @(posedge clk);
            out_ready <= random_bit();
        end
        @(negedge clk);
        assert (out_valid === 1'b0)
            else report_mismatch($sformatf("row %0d valid after", r), 0, 32'(out_valid));
        assert (status_ready === 1'b1)
            else report_mismatch($sformatf("row %0d ready after", r), 1, 32'(status_ready));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("** Error: test did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n        = 1'b0;
        status       = '0;
        status_valid = 1'b0;
        out_ready    = 1'b0;
        rows[0] = '{make_status(1'b0, 95, 90), make_status(1'b1, 0, 0)};
        rows[1] = '{make_status(1'b1, 0, 0), make_status(1'b0, 60, 90)};
        rows[2] = '{make_status(1'b0, 10, 20), make_status(1'b1, 95, 50)};
        rows[3] = '{make_status(1'b1, 20, 50), make_status(1'b0, 60, 0)};
        rows[4] = '{make_status(1'b0, 45, 90), make_status(1'b1, 10, 20)};
        rows[5] = '{make_status(1'b1, 75, 20), make_status(1'b0, 60, 50)};

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (out_valid === 1'b0)
            else report_mismatch("reset valid", 0, 32'(out_valid));
        assert (status_ready === 1'b1)
            else report_mismatch("reset ready", 1, 32'(status_ready));

        for (int r = 0; r < num_rows; r++) begin
            run_refresh(rows[r[2:0]], r == 0, r);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/oled_pkg.sv
design/pet_pkg.sv
design/refresh_fsm.sv
design/byte_counter.sv
design/init_cmd_rom.sv
design/status_overlay.sv
design/pet_display_top.sv
bench/tb_clock.sv
bench/pet_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module pet_display_tb \
    -f vlog.f -o pet_display_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/pet_display_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator returned status $sim_status"
    exit 1
fi
exit 0
